// File: Bender.yml
package:
  name: rv32i_byte_core

sources:
  - include_dirs:
      - hw
    files:
      - hw/cpu_pkg.sv
      - hw/mem_control.sv
      - hw/regfile.sv
      - hw/id.sv
      - hw/ex.sv
      - hw/core_ctrl.sv
      - hw/cpu.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - sim/ram_model.sv
      - sim/tb_cpu.sv

// File: hw/core_ctrl.sv
`include "cpu_params.svh"

module core_ctrl (
    input  logic                clk_in,
    input  logic                rst_n_i,
    input  logic                rdy_i,
    input  logic                done_i,
    input  logic [31:0]         rdata_i,
    input  cpu_pkg::inst_kind_e kind_i,
    input  logic                byte_i,
    input  logic [4:0]          rd_i,
    input  logic [31:0]         rs2_val_i,
    input  logic [31:0]         result_i,
    input  logic [31:0]         npc_i,
    output logic                req_o,
    output logic                we_o,
    output logic                byte_o,
    output logic [31:0]         addr_o,
    output logic [31:0]         wdata_o,
    output logic [31:0]         inst_o,
    output logic [31:0]         pc_o,
    output logic                rf_we_o,
    output logic [4:0]          rf_waddr_o,
    output logic [31:0]         rf_wdata_o
);

    cpu_pkg::core_state_e state_q;
    logic [31:0] pc_q;
    logic [31:0] ir_q;
    logic        pend_q;
    logic        is_ls;
    logic        in_mem;
    logic        wb_exec;

    assign in_mem = (state_q == cpu_pkg::S_MEM);
    assign is_ls = (kind_i == cpu_pkg::K_LOAD) || (kind_i == cpu_pkg::K_STORE);
    assign wb_exec = (state_q == cpu_pkg::S_EXEC) &&
                     ((kind_i == cpu_pkg::K_LUI) || (kind_i == cpu_pkg::K_OPIMM) ||
                      (kind_i == cpu_pkg::K_OP) || (kind_i == cpu_pkg::K_JAL));

    // Request goes out once per access, pend_q blocks it until done_i
    assign req_o = ((state_q == cpu_pkg::S_FETCH) || in_mem) && !pend_q;
    assign we_o = in_mem && (kind_i == cpu_pkg::K_STORE);
    assign byte_o = in_mem && byte_i;
    assign addr_o = in_mem ? result_i : pc_q;
    assign wdata_o = rs2_val_i;
    assign inst_o = ir_q;
    assign pc_o = pc_q;

    assign rf_we_o = wb_exec || (in_mem && done_i && (kind_i == cpu_pkg::K_LOAD));
    assign rf_waddr_o = rd_i;
    assign rf_wdata_o = in_mem ? rdata_i : result_i;

    always_ff @(posedge clk_in or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= cpu_pkg::S_FETCH;
            pc_q    <= `RESET_PC;
            pend_q  <= 1'b0;
        end else if (rdy_i) begin
            case (state_q)
                cpu_pkg::S_FETCH: begin
                    pend_q <= !done_i;
                    if (done_i) begin
                        state_q <= cpu_pkg::S_EXEC;
                    end
                end
                cpu_pkg::S_EXEC: begin
                    if (kind_i == cpu_pkg::K_ILLEGAL) begin
                        state_q <= cpu_pkg::S_HALT;
                    end else begin
                        pc_q    <= npc_i;
                        state_q <= is_ls ? cpu_pkg::S_MEM : cpu_pkg::S_FETCH;
                    end
                end
                cpu_pkg::S_MEM: begin
                    pend_q <= !done_i;
                    if (done_i) begin
                        state_q <= cpu_pkg::S_FETCH;
                    end
                end
                default: state_q <= cpu_pkg::S_HALT;
            endcase
        end
    end

    always_ff @(posedge clk_in) begin
        if (rdy_i && (state_q == cpu_pkg::S_FETCH) && done_i) begin
            ir_q <= rdata_i;
        end
    end

    a_pc_aligned: assert property (
        @(posedge clk_in) disable iff (!rst_n_i) pc_q[1:0] == 2'b00);

endmodule

// File: hw/cpu.sv
module cpu (
    input  logic        clk_in,
    input  logic        rst_n_i,
    input  logic        rdy_i,
    input  logic [7:0]  mem_din_i,
    output logic [7:0]  mem_dout_o,
    output logic [31:0] mem_a_o,
    output logic        mem_wr_o,
    output logic [31:0] dbgreg_dout_o
);

    // Sequencer to memory controller
    logic        mc_req;
    logic        mc_we;
    logic        mc_byte;
    logic [31:0] mc_addr;
    logic [31:0] mc_wdata;
    logic        mc_done;
    logic [31:0] mc_rdata;

    logic [31:0] inst;
    logic [31:0] pc;

    // Decoded fields
    cpu_pkg::inst_kind_e kind;
    cpu_pkg::alu_op_e    alu_op;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    logic [31:0] imm;
    logic        id_byte;
    logic        alu_imm;

    logic [31:0] rs1_val;
    logic [31:0] rs2_val;
    logic [31:0] result;
    logic [31:0] npc;

    // Writeback
    logic        rf_we;
    logic [4:0]  rf_waddr;
    logic [31:0] rf_wdata;

    mem_control u_mem_control (
        .clk_in     (clk_in),
        .rst_n_i    (rst_n_i),
        .rdy_i      (rdy_i),
        .req_i      (mc_req),
        .we_i       (mc_we),
        .byte_i     (mc_byte),
        .addr_i     (mc_addr),
        .wdata_i    (mc_wdata),
        .mem_din_i  (mem_din_i),
        .done_o     (mc_done),
        .rdata_o    (mc_rdata),
        .mem_dout_o (mem_dout_o),
        .mem_a_o    (mem_a_o),
        .mem_wr_o   (mem_wr_o)
    );

    regfile u_regfile (
        .clk_in   (clk_in),
        .rst_n_i  (rst_n_i),
        .rdy_i    (rdy_i),
        .we_i     (rf_we),
        .waddr_i  (rf_waddr),
        .wdata_i  (rf_wdata),
        .raddr1_i (rs1),
        .raddr2_i (rs2),
        .rdata1_o (rs1_val),
        .rdata2_o (rs2_val),
        .dbg_o    (dbgreg_dout_o)
    );

    id u_id (
        .inst_i    (inst),
        .kind_o    (kind),
        .alu_op_o  (alu_op),
        .rs1_o     (rs1),
        .rs2_o     (rs2),
        .rd_o      (rd),
        .imm_o     (imm),
        .byte_o    (id_byte),
        .alu_imm_o (alu_imm)
    );

    ex u_ex (
        .kind_i    (kind),
        .alu_op_i  (alu_op),
        .alu_imm_i (alu_imm),
        .rs1_val_i (rs1_val),
        .rs2_val_i (rs2_val),
        .imm_i     (imm),
        .pc_i      (pc),
        .result_o  (result),
        .npc_o     (npc)
    );

    core_ctrl u_core_ctrl (
        .clk_in     (clk_in),
        .rst_n_i    (rst_n_i),
        .rdy_i      (rdy_i),
        .done_i     (mc_done),
        .rdata_i    (mc_rdata),
        .kind_i     (kind),
        .byte_i     (id_byte),
        .rd_i       (rd),
        .rs2_val_i  (rs2_val),
        .result_i   (result),
        .npc_i      (npc),
        .req_o      (mc_req),
        .we_o       (mc_we),
        .byte_o     (mc_byte),
        .addr_o     (mc_addr),
        .wdata_o    (mc_wdata),
        .inst_o     (inst),
        .pc_o       (pc),
        .rf_we_o    (rf_we),
        .rf_waddr_o (rf_waddr),
        .rf_wdata_o (rf_wdata)
    );

endmodule

// File: hw/cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// Core start address
`define RESET_PC 32'h0000_0000

// Address bits that reach the memory port
`define ADDR_BITS 18

// Register shown on the debug output (a0)
`define DBG_REG 10

// RV32I opcode field values
`define OPC_LUI    7'b0110111
`define OPC_OPIMM  7'b0010011
`define OPC_OP     7'b0110011
`define OPC_LOAD   7'b0000011
`define OPC_STORE  7'b0100011
`define OPC_BRANCH 7'b1100011
`define OPC_JAL    7'b1101111

`endif

// File: hw/cpu_pkg.sv
package cpu_pkg;

    // Decoded instruction class
    typedef enum logic [2:0] {
        K_LUI,
        K_OPIMM,
        K_OP,
        K_LOAD,
        K_STORE,
        K_BRANCH,
        K_JAL,
        K_ILLEGAL
    } inst_kind_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_PASS_B
    } alu_op_e;

    typedef enum logic [1:0] {S_FETCH, S_EXEC, S_MEM, S_HALT} core_state_e;

    typedef enum logic [1:0] {MC_IDLE, MC_READ, MC_WRITE} mc_state_e;

endpackage

// File: hw/ex.sv
module ex (
    input  cpu_pkg::inst_kind_e kind_i,
    input  cpu_pkg::alu_op_e    alu_op_i,
    input  logic                alu_imm_i,
    input  logic [31:0]         rs1_val_i,
    input  logic [31:0]         rs2_val_i,
    input  logic [31:0]         imm_i,
    input  logic [31:0]         pc_i,
    output logic [31:0]         result_o,
    output logic [31:0]         npc_o
);

    logic [31:0] opb;
    logic [31:0] alu_res;
    logic [31:0] pc_plus4;
    logic [31:0] target;
    logic        taken;

    assign opb = alu_imm_i ? imm_i : rs2_val_i;

    always_comb begin
        case (alu_op_i)
            cpu_pkg::ALU_ADD: alu_res = rs1_val_i + opb;
            cpu_pkg::ALU_SUB: alu_res = rs1_val_i - opb;
            cpu_pkg::ALU_AND: alu_res = rs1_val_i & opb;
            cpu_pkg::ALU_OR:  alu_res = rs1_val_i | opb;
            cpu_pkg::ALU_XOR: alu_res = rs1_val_i ^ opb;
            default:          alu_res = opb;
        endcase
    end

    assign pc_plus4 = pc_i + 32'd4;
    assign target = pc_i + imm_i;

    // Zero difference means equal; the XOR form marks BNE
    assign taken = (kind_i == cpu_pkg::K_JAL) ||
                   ((kind_i == cpu_pkg::K_BRANCH) &&
                    ((alu_res == 32'd0) != (alu_op_i == cpu_pkg::ALU_XOR)));

    // JAL links pc+4, everything else returns the ALU value or address
    assign result_o = (kind_i == cpu_pkg::K_JAL) ? pc_plus4 : alu_res;
    assign npc_o = taken ? target : pc_plus4;

endmodule

// File: hw/id.sv
`include "cpu_params.svh"

module id (
    input  logic [31:0]         inst_i,
    output cpu_pkg::inst_kind_e kind_o,
    output cpu_pkg::alu_op_e    alu_op_o,
    output logic [4:0]          rs1_o,
    output logic [4:0]          rs2_o,
    output logic [4:0]          rd_o,
    output logic [31:0]         imm_o,
    output logic                byte_o,
    output logic                alu_imm_o
);

    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [31:0] imm_itype;
    logic [31:0] imm_stype;
    logic [31:0] imm_btype;
    logic [31:0] imm_utype;
    logic [31:0] imm_jtype;

    assign opcode = inst_i[6:0];
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];
    assign rd_o  = inst_i[11:7];
    assign rs1_o = inst_i[19:15];
    assign rs2_o = inst_i[24:20];

    // Immediate formats, all sign-extended from bit 31
    assign imm_itype = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_stype = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
    assign imm_btype = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25],
                        inst_i[11:8], 1'b0};
    assign imm_utype = {inst_i[31:12], 12'd0};
    assign imm_jtype = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20],
                        inst_i[30:21], 1'b0};

    always_comb begin
        kind_o    = cpu_pkg::K_ILLEGAL;
        alu_op_o  = cpu_pkg::ALU_ADD;
        imm_o     = imm_itype;
        byte_o    = 1'b0;
        alu_imm_o = 1'b0;
        case (opcode)
            `OPC_LUI: begin
                kind_o    = cpu_pkg::K_LUI;
                alu_op_o  = cpu_pkg::ALU_PASS_B;
                imm_o     = imm_utype;
                alu_imm_o = 1'b1;
            end
            `OPC_OPIMM: begin
                alu_imm_o = 1'b1;
                // ADDI only
                if (funct3 == 3'b000) begin
                    kind_o = cpu_pkg::K_OPIMM;
                end
            end
            `OPC_OP: begin
                if (funct7 == 7'b0000000) begin
                    kind_o = cpu_pkg::K_OP;
                    case (funct3)
                        3'b000:  alu_op_o = cpu_pkg::ALU_ADD;
                        3'b100:  alu_op_o = cpu_pkg::ALU_XOR;
                        3'b110:  alu_op_o = cpu_pkg::ALU_OR;
                        3'b111:  alu_op_o = cpu_pkg::ALU_AND;
                        default: kind_o = cpu_pkg::K_ILLEGAL;
                    endcase
                end else if ((funct7 == 7'b0100000) && (funct3 == 3'b000)) begin
                    kind_o   = cpu_pkg::K_OP;
                    alu_op_o = cpu_pkg::ALU_SUB;
                end
            end
            `OPC_LOAD: begin
                alu_imm_o = 1'b1;
                byte_o    = (funct3 == 3'b100);
                if ((funct3 == 3'b010) || (funct3 == 3'b100)) begin
                    kind_o = cpu_pkg::K_LOAD;
                end
            end
            `OPC_STORE: begin
                imm_o     = imm_stype;
                alu_imm_o = 1'b1;
                byte_o    = (funct3 == 3'b000);
                if ((funct3 == 3'b010) || (funct3 == 3'b000)) begin
                    kind_o = cpu_pkg::K_STORE;
                end
            end
            `OPC_BRANCH: begin
                imm_o = imm_btype;
                // BEQ compares by SUB, BNE by XOR
                alu_op_o = funct3[0] ? cpu_pkg::ALU_XOR : cpu_pkg::ALU_SUB;
                if (funct3[2:1] == 2'b00) begin
                    kind_o = cpu_pkg::K_BRANCH;
                end
            end
            `OPC_JAL: begin
                kind_o = cpu_pkg::K_JAL;
                imm_o  = imm_jtype;
            end
            default: kind_o = cpu_pkg::K_ILLEGAL;
        endcase
    end

endmodule

// File: hw/mem_control.sv
`include "cpu_params.svh"

module mem_control (
    input  logic        clk_in,
    input  logic        rst_n_i,
    input  logic        rdy_i,
    input  logic        req_i,
    input  logic        we_i,
    input  logic        byte_i,
    input  logic [31:0] addr_i,
    input  logic [31:0] wdata_i,
    input  logic [7:0]  mem_din_i,
    output logic        done_o,
    output logic [31:0] rdata_o,
    output logic [7:0]  mem_dout_o,
    output logic [31:0] mem_a_o,
    output logic        mem_wr_o
);

    cpu_pkg::mc_state_e state_q;
    logic [31:0] base_q;
    logic [1:0]  idx_q;
    logic        byte_q;
    logic        inflight_q;
    logic        rdy_q;
    logic [31:0] wdata_q;
    logic [23:0] rbuf_q;
    logic        valid;
    logic        last;
    logic [31:0] addr_sum;

    // Byte on mem_din_i is for idx_q only if its address went out last cycle
    assign valid = inflight_q && rdy_q;
    assign last = byte_q || (idx_q == 2'd3);

    // While a byte returns, the next offset is already on the bus
    assign addr_sum = base_q + {29'd0, {1'b0, idx_q} + {2'b00, valid}};
    assign mem_a_o = {{(32 - `ADDR_BITS){1'b0}}, addr_sum[`ADDR_BITS-1:0]};

    assign mem_wr_o = (state_q == cpu_pkg::MC_WRITE) && rdy_i;
    assign mem_dout_o = wdata_q[8*idx_q +: 8];

    assign done_o = rdy_i && last &&
                    (((state_q == cpu_pkg::MC_READ) && valid) ||
                     (state_q == cpu_pkg::MC_WRITE));
    assign rdata_o = byte_q ? {24'd0, mem_din_i} : {mem_din_i, rbuf_q};

    always_ff @(posedge clk_in or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q    <= cpu_pkg::MC_IDLE;
            base_q     <= 32'd0;
            idx_q      <= 2'd0;
            byte_q     <= 1'b0;
            inflight_q <= 1'b0;
            rdy_q      <= 1'b0;
        end else begin
            rdy_q <= rdy_i;
            if (rdy_i) begin
                case (state_q)
                    cpu_pkg::MC_IDLE: begin
                        if (req_i) begin
                            state_q    <= we_i ? cpu_pkg::MC_WRITE : cpu_pkg::MC_READ;
                            base_q     <= addr_i;
                            idx_q      <= 2'd0;
                            byte_q     <= byte_i;
                            inflight_q <= 1'b0;
                        end
                    end
                    cpu_pkg::MC_READ: begin
                        // Lost bytes are simply issued again at idx_q
                        inflight_q <= !(valid && last);
                        if (valid) begin
                            idx_q <= last ? 2'd0 : idx_q + 2'd1;
                            if (last) begin
                                state_q <= cpu_pkg::MC_IDLE;
                            end
                        end
                    end
                    cpu_pkg::MC_WRITE: begin
                        idx_q <= last ? 2'd0 : idx_q + 2'd1;
                        if (last) begin
                            state_q <= cpu_pkg::MC_IDLE;
                        end
                    end
                    default: state_q <= cpu_pkg::MC_IDLE;
                endcase
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (rdy_i) begin
            if ((state_q == cpu_pkg::MC_IDLE) && req_i) begin
                wdata_q <= wdata_i;
            end
            // Little-endian assembly, oldest byte ends up lowest
            if ((state_q == cpu_pkg::MC_READ) && valid) begin
                rbuf_q <= {mem_din_i, rbuf_q[23:8]};
            end
        end
    end

    a_no_wr_when_frozen: assert property (
        @(posedge clk_in) disable iff (!rst_n_i) !rdy_i |-> !mem_wr_o);

    a_done_single: assert property (
        @(posedge clk_in) disable iff (!rst_n_i) done_o |=> !done_o);

endmodule

// File: hw/regfile.sv
`include "cpu_params.svh"

module regfile (
    input  logic        clk_in,
    input  logic        rst_n_i,
    input  logic        rdy_i,
    input  logic        we_i,
    input  logic [4:0]  waddr_i,
    input  logic [31:0] wdata_i,
    input  logic [4:0]  raddr1_i,
    input  logic [4:0]  raddr2_i,
    output logic [31:0] rdata1_o,
    output logic [31:0] rdata2_o,
    output logic [31:0] dbg_o
);

    // x0 has no storage
    logic [31:0] regs_q [1:31];

    always_ff @(posedge clk_in or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                regs_q[i] <= 32'd0;
            end
        end else if (rdy_i && we_i && (waddr_i != 5'd0)) begin
            regs_q[waddr_i] <= wdata_i;
        end
    end

    assign rdata1_o = (raddr1_i == 5'd0) ? 32'd0 : regs_q[raddr1_i];
    assign rdata2_o = (raddr2_i == 5'd0) ? 32'd0 : regs_q[raddr2_i];
    assign dbg_o = regs_q[`DBG_REG];

    // Accepted write lands in the addressed register
    a_write_lands: assert property (
        @(posedge clk_in) disable iff (!rst_n_i)
        (we_i && rdy_i && (waddr_i != 5'd0)) |=>
            (regs_q[$past(waddr_i)] == $past(wdata_i)));

endmodule

// File: sim.f
+incdir+hw
hw/cpu_pkg.sv
hw/mem_control.sv
hw/regfile.sv
hw/id.sv
hw/ex.sv
hw/core_ctrl.sv
hw/cpu.sv
sim/ram_model.sv
sim/tb_cpu.sv

// File: sim/ram_model.sv
module ram_model (
    input  logic        clk_in,
    input  logic [31:0] addr_i,
    input  logic [7:0]  din_i,
    input  logic        wr_i,
    output logic [7:0]  dout_o,
    output logic        stop_o
);

    localparam int RAM_BYTES = 131072;

    logic [7:0] mem [0:RAM_BYTES-1];

    // Bytes seen at the output port 0x30000
    logic [7:0] out_bytes [0:15];
    int         out_count;

    initial begin
        // Pattern mixes every address bit so stray reads are visible
        for (int i = 0; i < RAM_BYTES; i++) begin
            mem[i] = i[7:0] ^ i[15:8] ^ {7'd0, i[16]};
        end
        out_count = 0;
        stop_o = 1'b0;
        dout_o = 8'h00;
    end

    always @(posedge clk_in) begin
        stop_o <= 1'b0;
        if (wr_i) begin
            if (!addr_i[17]) begin
                mem[addr_i[16:0]] <= din_i;
            end else if (addr_i[17:0] == 18'h30000) begin
                if (out_count < 16) begin
                    out_bytes[out_count] <= din_i;
                end
                out_count <= out_count + 1;
            end else if (addr_i[17:0] == 18'h30004) begin
                stop_o <= 1'b1;
            end
        end
        // I/O region reads back as zero
        dout_o <= addr_i[17] ? 8'h00 : mem[addr_i[16:0]];
    end

endmodule

// File: sim/tb_cpu.sv
`include "cpu_params.svh"

module tb_cpu;

    // About 70 instructions at up to 12 cycles, doubled for stalls, plus margin
    localparam int TIMEOUT_CYCLES = 6000;
    localparam int SCRATCH = 32'h1000;
    localparam int TABLE = 32'h1100;

    logic        clk_in;
    logic        rst_n;
    logic        rdy;
    logic [7:0]  mem_din;
    logic [7:0]  mem_dout;
    logic [31:0] mem_a;
    logic        mem_wr;
    logic [31:0] dbg;
    logic        stop;

    logic [31:0] rng_state;
    logic [31:0] op_a;
    logic [31:0] op_b;
    logic [31:0] sum_exp;
    logic [7:0]  table_bytes [0:2];
    int          prog_addr;
    int          cycles;
    int          checks;
    int          errors;

    cpu uut (
        .clk_in        (clk_in),
        .rst_n_i       (rst_n),
        .rdy_i         (rdy),
        .mem_din_i     (mem_din),
        .mem_dout_o    (mem_dout),
        .mem_a_o       (mem_a),
        .mem_wr_o      (mem_wr),
        .dbgreg_dout_o (dbg)
    );

    ram_model u_ram (
        .clk_in (clk_in),
        .addr_i (mem_a),
        .din_i  (mem_dout),
        .wr_i   (mem_wr),
        .dout_o (mem_din),
        .stop_o (stop)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function automatic logic [31:0] itype(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] rtype(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, `OPC_OP};
    endfunction

    function automatic logic [31:0] stype(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], `OPC_STORE};
    endfunction

    function automatic logic [31:0] btype(input logic [12:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `OPC_BRANCH};
    endfunction

    function automatic logic [31:0] utype(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, `OPC_LUI};
    endfunction

    function automatic logic [31:0] jtype(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `OPC_JAL};
    endfunction

    function automatic logic [31:0] read_word(input int addr);
        return {u_ram.mem[addr+3], u_ram.mem[addr+2], u_ram.mem[addr+1], u_ram.mem[addr]};
    endfunction

    task automatic place_word(input logic [31:0] word);
        for (int i = 0; i < 4; i++) begin
            u_ram.mem[prog_addr+i] = word[8*i +: 8];
        end
        prog_addr += 4;
    endtask

    task automatic load_program();
        int loop_addr;
        prog_addr = `RESET_PC;
        // Operands in x1 and x2, scratch base in x3
        place_word(utype(20'h12345, 5'd1));
        place_word(itype(12'h678, 5'd1, 3'b000, 5'd1, `OPC_OPIMM));
        place_word(utype(20'h0f0f1, 5'd2));
        place_word(itype(12'hff0, 5'd2, 3'b000, 5'd2, `OPC_OPIMM));
        place_word(utype(20'h00001, 5'd3));
        place_word(rtype(7'h00, 5'd2, 5'd1, 3'b000, 5'd4));
        place_word(stype(12'd0, 5'd4, 5'd3, 3'b010));
        place_word(rtype(7'h20, 5'd2, 5'd1, 3'b000, 5'd4));
        place_word(stype(12'd4, 5'd4, 5'd3, 3'b010));
        place_word(rtype(7'h00, 5'd2, 5'd1, 3'b111, 5'd4));
        place_word(stype(12'd8, 5'd4, 5'd3, 3'b010));
        place_word(rtype(7'h00, 5'd2, 5'd1, 3'b110, 5'd4));
        place_word(stype(12'd12, 5'd4, 5'd3, 3'b010));
        place_word(rtype(7'h00, 5'd2, 5'd1, 3'b100, 5'd4));
        place_word(stype(12'd16, 5'd4, 5'd3, 3'b010));
        // Sum 1..10 in x5, running total stored every pass
        place_word(itype(12'd0, 5'd0, 3'b000, 5'd5, `OPC_OPIMM));
        place_word(itype(12'd1, 5'd0, 3'b000, 5'd6, `OPC_OPIMM));
        place_word(itype(12'd11, 5'd0, 3'b000, 5'd7, `OPC_OPIMM));
        loop_addr = prog_addr;
        place_word(rtype(7'h00, 5'd6, 5'd5, 3'b000, 5'd5));
        place_word(stype(12'd32, 5'd5, 5'd3, 3'b010));
        place_word(itype(12'd1, 5'd6, 3'b000, 5'd6, `OPC_OPIMM));
        place_word(btype(loop_addr - prog_addr, 5'd7, 5'd6, 3'b001));
        place_word(itype(12'd32, 5'd3, 3'b010, 5'd10, `OPC_LOAD));
        // Jump over the poisoning ADDI
        place_word(jtype(21'd8, 5'd0));
        place_word(itype(12'd99, 5'd10, 3'b000, 5'd10, `OPC_OPIMM));
        place_word(utype(20'h00030, 5'd8));
        place_word(itype(12'h100, 5'd3, 3'b000, 5'd9, `OPC_OPIMM));
        for (int k = 0; k < 3; k++) begin
            place_word(itype(k, 5'd9, 3'b100, 5'd11, `OPC_LOAD));
            place_word(stype(12'd0, 5'd11, 5'd8, 3'b000));
        end
        place_word(stype(12'd4, 5'd0, 5'd8, 3'b010));
        // Illegal word halts the core
        place_word(32'h0000_0000);
        for (int k = 0; k < 3; k++) begin
            u_ram.mem[TABLE+k] = table_bytes[k];
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("ERR %0t %s: got %h expected %h", $time, name, got, exp);
        end
    endtask

    always #10 clk_in = ~clk_in;

    // Ready low in about one cycle in four
    always @(posedge clk_in) begin
        #2;
        rng_state = xorshift(rng_state);
        rdy = (rng_state[1:0] != 2'b00);
    end

    a_no_wr_frozen: assert property (
        @(posedge clk_in) disable iff (!rst_n) !(mem_wr && !rdy))
    else begin
        errors++;
        $display("mem_wr_o was high while rdy_i was low at %0t", $time);
    end

    always @(posedge clk_in) begin
        cycles <= cycles + 1;
        if (cycles == TIMEOUT_CYCLES) begin
            $display("Program did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("checks %0d, errors %0d", checks, errors + 1);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    initial begin
        clk_in = 1'b0;
        rst_n = 1'b0;
        rdy = 1'b1;
        rng_state = 32'h10d3_bb31;
        cycles = 0;
        checks = 0;
        errors = 0;
        table_bytes[0] = "O";
        table_bytes[1] = "K";
        table_bytes[2] = 8'h0a;
        #1;
        load_program();

        repeat (3) @(posedge clk_in);
        #2;
        rst_n = 1'b1;
        @(negedge clk_in);
        check_word("mem_wr_o", {31'd0, mem_wr}, 32'd0);
        check_word("mem_a_o", mem_a, `RESET_PC);

        do begin
            @(negedge clk_in);
        end while (!stop);

        op_a = (32'h12345 << 12) + sext12(12'h678);
        op_b = (32'h0f0f1 << 12) + sext12(12'hff0);
        check_word("scratch_add", read_word(SCRATCH), op_a + op_b);
        check_word("scratch_sub", read_word(SCRATCH + 4), op_a - op_b);
        check_word("scratch_and", read_word(SCRATCH + 8), op_a & op_b);
        check_word("scratch_or", read_word(SCRATCH + 12), op_a | op_b);
        check_word("scratch_xor", read_word(SCRATCH + 16), op_a ^ op_b);

        sum_exp = 0;
        for (int i = 1; i <= 10; i++) begin
            sum_exp += i;
        end
        check_word("sum_word", read_word(SCRATCH + 32), sum_exp);
        check_word("dbgreg_dout_o", dbg, sum_exp);

        check_word("out_count", u_ram.out_count, 32'd3);
        for (int k = 0; k < 3; k++) begin
            check_word($sformatf("out_byte%0d", k), {24'd0, u_ram.out_bytes[k]},
                       {24'd0, table_bytes[k]});
        end

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule
